// ==== verilog.f ====
rtl/hacd_axi_pkg.sv
rtl/hacd_table_pkg.sv
rtl/hacd_line_mem.sv
rtl/hacd_axi_wr_ctrl.sv
rtl/hacd_bresp_fifo.sv
rtl/hacd_axi_rd_ctrl.sv
rtl/hacd_table_inspect.sv
rtl/hacd_axi_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_hacd_axi_mem.sv

// ==== Makefile ====
SIM        := verilator
TOP        := tb_hacd_axi_mem
FILELIST   := verilog.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
PASS_LINE  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qxF '$(PASS_LINE)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_hacd_axi_mem.sv ====
`timescale 1ns/1ps

module tb_hacd_axi_mem
  import hacd_axi_pkg::*;
  import hacd_table_pkg::*;
();

  localparam int mem_lines   = 64;
  localparam int bresp_depth = 4;
  localparam int lw          = $clog2(mem_lines);
  localparam int timeout     = 50; // cycles per wait
  localparam int rd_lat      = 3;  // handshake cycle to first rvalid cycle
  localparam int insp_lat    = 2;  // request cycle to inspect_valid cycle
  localparam logic [31:0] all_bytes = 32'hffff_ffff;

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_inspect,
    op_bhold,    // bready low from here
    op_brelease  // check back-pressure, then drain responses
  } op_e;

  typedef struct packed {
    op_e                   kind;
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
    logic [axi_data_w-1:0] data0;
    logic [axi_data_w-1:0] data1;
    logic [axi_strb_w-1:0] strb0;
    logic [axi_strb_w-1:0] strb1;
    table_region_e         region;
    logic [3:0]            stall;  // extra rready low cycles per beat
  } row_t;

  logic                  clk;
  logic                  rst_n;
  axi_aw_t               aw;
  axi_w_t                w;
  axi_ar_t               ar;
  logic                  bready;
  logic                  rready;
  logic                  inspect_req;
  logic [axi_addr_w-1:0] inspect_addr;
  logic                  awready;
  logic                  wready;
  logic                  arready;
  axi_b_t                b;
  axi_r_t                r;
  logic                  inspect_valid;
  table_region_e         inspect_region;
  table_beat_u           inspect_beat;

  logic [axi_data_w-1:0] shadow [mem_lines*max_beats]; // expected memory image
  row_t                  rows[$];
  logic [axi_id_w-1:0]   bid_q[$];  // awids still owed a response in write order
  int                    errors;
  int                    timeouts;
  int                    writes;
  int                    b_seen;

  tb_clk_gen #(.half_period(20), .rst_cycles(3)) u_clk_gen (.clk, .rst_n);

  hacd_axi_mem_top #(.mem_lines(mem_lines), .bresp_depth(bresp_depth)) hacd_axi_mem_top_inst (
    .clk, .rst_n, .aw, .w, .ar, .bready, .rready, .inspect_req, .inspect_addr,
    .awready, .wready, .arready, .b, .r, .inspect_valid, .inspect_region, .inspect_beat
  );

  task automatic report_mismatch(input string name, input logic [255:0] exp,
                                 input logic [255:0] act);
    errors++;
    $display("[FAIL] %s exp %0h act %0h", name, exp, act);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s, gave up after %0d cycles", what, timeout);
  endtask

  function automatic logic [axi_data_w-1:0] rand_beat();
    logic [axi_data_w-1:0] v;
    int k;
    for (k = 0; k < axi_data_w / 32; k++) begin
      v[k*32 +: 32] = $urandom();
    end
    return v;
  endfunction

  // only enabled bytes take new data
  function automatic void shadow_write(input logic [lw:0] idx, input logic [axi_data_w-1:0] d,
                                       input logic [axi_strb_w-1:0] s);
    int k;
    for (k = 0; k < axi_strb_w; k++) begin
      if (s[k]) shadow[idx][k*8 +: 8] = d[k*8 +: 8];
    end
  endfunction

  task automatic add_row(input op_e kind, input logic [axi_id_w-1:0] id,
                         input logic [axi_addr_w-1:0] addr, input logic [7:0] len,
                         input logic [axi_strb_w-1:0] strb0, input logic [axi_strb_w-1:0] strb1,
                         input table_region_e region, input logic [3:0] stall);
    row_t rw;
    rw.kind   = kind;
    rw.id     = id;
    rw.addr   = addr;
    rw.len    = len;
    rw.data0  = rand_beat();
    rw.data1  = rand_beat();
    rw.strb0  = strb0;
    rw.strb1  = strb1;
    rw.region = region;
    rw.stall  = stall;
    rows.push_back(rw);
  endtask

  task automatic build_table();
    add_row(op_write,    6'h01, 64'h040, 8'd1, all_bytes, all_bytes, region_none, 4'd0);
    add_row(op_read,     6'h02, 64'h040, 8'd1, '0, '0, region_none, 4'd0);
    add_row(op_write,    6'h03, 64'h040, 8'd1, 32'h0000_ff0f, 32'hf000_00a5, region_none, 4'd0);
    add_row(op_read,     6'h04, 64'h040, 8'd1, '0, '0, region_none, 4'd3);
    add_row(op_write,    6'h05, 64'h400, 8'd1, all_bytes, all_bytes, region_att, 4'd0);
    add_row(op_write,    6'h06, 64'h800, 8'd1, all_bytes, all_bytes, region_list, 4'd0);
    add_row(op_write,    6'h07, 64'hc40, 8'd0, all_bytes, '0, region_none, 4'd0);
    add_row(op_inspect,  6'h00, 64'h400, 8'd0, '0, '0, region_att, 4'd0);
    add_row(op_inspect,  6'h00, 64'h420, 8'd0, '0, '0, region_att, 4'd0);  // beat 1
    add_row(op_inspect,  6'h00, 64'h800, 8'd0, '0, '0, region_list, 4'd0);
    add_row(op_inspect,  6'h00, 64'h820, 8'd0, '0, '0, region_list, 4'd0);
    add_row(op_inspect,  6'h00, 64'hc40, 8'd0, '0, '0, region_none, 4'd0); // past ppa base
    add_row(op_write,    6'h08, 64'h400, 8'd0, 32'h00ff_00ff, '0, region_att, 4'd0);
    add_row(op_inspect,  6'h00, 64'h400, 8'd0, '0, '0, region_att, 4'd0);
    add_row(op_bhold,    6'h00, 64'h000, 8'd0, '0, '0, region_none, 4'd0);
    add_row(op_write,    6'h0a, 64'h080, 8'd1, all_bytes, all_bytes, region_none, 4'd0);
    add_row(op_write,    6'h0b, 64'h0c0, 8'd0, all_bytes, '0, region_none, 4'd0);
    add_row(op_write,    6'h0c, 64'h100, 8'd1, all_bytes, all_bytes, region_none, 4'd0);
    add_row(op_write,    6'h0d, 64'h140, 8'd1, all_bytes, all_bytes, region_none, 4'd0);
    add_row(op_brelease, 6'h00, 64'h000, 8'd0, '0, '0, region_none, 4'd0);
    add_row(op_read,     6'h0e, 64'h080, 8'd1, '0, '0, region_none, 4'd1);
    add_row(op_read,     6'h0f, 64'h0c0, 8'd0, '0, '0, region_none, 4'd2);
    add_row(op_read,     6'h10, 64'h140, 8'd1, '0, '0, region_none, 4'd5);
    add_row(op_read,     6'h11, 64'h800, 8'd1, '0, '0, region_none, 4'd0);
    add_row(op_read,     6'h12, 64'h400, 8'd0, '0, '0, region_none, 4'd1);
  endtask

  task automatic do_write(input row_t rw);
    int n;
    int i;
    int nbeats;
    logic [axi_data_w-1:0] d;
    logic [axi_strb_w-1:0] s;
    nbeats   = int'(rw.len) + 1;
    aw.valid = 1'b1;
    aw.id    = rw.id;
    aw.addr  = rw.addr;
    aw.len   = rw.len;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!awready && n < timeout);
    if (!awready) begin
      report_timeout("awready");
      aw.valid = 1'b0;
      return;
    end
    @(posedge clk); // aw handshake
    #1;
    aw.valid = 1'b0;
    bid_q.push_back(rw.id);
    writes++;
    for (i = 0; i < nbeats; i++) begin
      d = (i == 0) ? rw.data0 : rw.data1;
      s = (i == 0) ? rw.strb0 : rw.strb1;
      w.valid = 1'b1;
      w.data  = d;
      w.strb  = s;
      w.last  = (i == nbeats - 1);
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!wready && n < timeout);
      if (!wready) begin
        report_timeout("wready");
        w.valid = 1'b0;
        return;
      end
      @(posedge clk); // beat taken here
      #1;
      shadow_write({rw.addr[lw+5:6], i[0]}, d, s);
    end
    w.valid = 1'b0;
    w.last  = 1'b0;
  endtask

  task automatic do_read(input row_t rw);
    int n;
    int i;
    int k;
    int nbeats;
    logic [lw:0] idx;
    nbeats   = int'(rw.len) + 1;
    ar.valid = 1'b1;
    ar.id    = rw.id;
    ar.addr  = rw.addr;
    ar.len   = rw.len;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < timeout);
    if (!arready) begin
      report_timeout("arready");
      ar.valid = 1'b0;
      return;
    end
    @(posedge clk); // ar handshake
    #1;
    ar.valid = 1'b0;
    for (i = 0; i < nbeats; i++) begin
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!r.valid && n < timeout);
      if (!r.valid) begin
        report_timeout("rvalid");
        return;
      end
      idx = {rw.addr[lw+5:6], i[0]};
      if (n != rd_lat) report_mismatch("rvalid latency", 256'(rd_lat), 256'(n));
      if (r.data !== shadow[idx]) report_mismatch("rdata", shadow[idx], r.data);
      if (r.id !== rw.id) report_mismatch("rid", 256'(rw.id), 256'(r.id));
      if (r.last !== (i == nbeats - 1))
        report_mismatch("rlast", 256'(i == nbeats - 1), 256'(r.last));
      if (r.resp !== 2'b00) report_mismatch("rresp", 256'(0), 256'(r.resp));
      // one low-rready cycle always plus the row's stall
      for (k = 0; k < int'(rw.stall); k++) begin
        @(negedge clk);
        if (r.valid !== 1'b1) report_mismatch("rvalid", 256'(1), 256'(r.valid));
        if (r.data !== shadow[idx]) report_mismatch("rdata", shadow[idx], r.data);
        if (r.last !== (i == nbeats - 1))
          report_mismatch("rlast", 256'(i == nbeats - 1), 256'(r.last));
      end
      @(posedge clk);
      #1;
      rready = 1'b1;
      @(posedge clk); // r handshake
      #1;
      rready = 1'b0;
    end
    @(negedge clk);
    if (arready !== 1'b1) report_mismatch("arready", 256'(1), 256'(arready));
    if (r.valid !== 1'b0) report_mismatch("rvalid", 256'(0), 256'(r.valid)); // no extra beat
  endtask

  task automatic do_inspect(input row_t rw);
    int n;
    int i;
    logic [axi_data_w-1:0] e;
    inspect_req  = 1'b1;
    inspect_addr = rw.addr;
    @(posedge clk);
    #1;
    inspect_req = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!inspect_valid && n < timeout);
    if (!inspect_valid) begin
      report_timeout("inspect_valid");
      return;
    end
    if (n != insp_lat) report_mismatch("inspect_valid latency", 256'(insp_lat), 256'(n));
    e = shadow[rw.addr[lw+5:5]]; // line and beat straight from the address
    if (inspect_region !== rw.region)
      report_mismatch("inspect_region", 256'(rw.region), 256'(inspect_region));
    case (rw.region)
      region_att: begin
        for (i = 0; i < 4; i++) begin // 64 bit entries
          if (inspect_beat.att[i].zpd_cnt !== e[64*i+57 +: 7])
            report_mismatch("att zpd_cnt", 256'(e[64*i+57 +: 7]),
                            256'(inspect_beat.att[i].zpd_cnt));
          if (inspect_beat.att[i].way !== e[64*i+2 +: 55])
            report_mismatch("att way", 256'(e[64*i+2 +: 55]), 256'(inspect_beat.att[i].way));
          if (inspect_beat.att[i].sts !== e[64*i +: 2])
            report_mismatch("att sts", 256'(e[64*i +: 2]), 256'(inspect_beat.att[i].sts));
        end
      end
      region_list: begin
        for (i = 0; i < 2; i++) begin // 128 bit entries
          if (inspect_beat.lst[i].rsvd !== e[128*i+114 +: 14])
            report_mismatch("list rsvd", 256'(e[128*i+114 +: 14]),
                            256'(inspect_beat.lst[i].rsvd));
          if (inspect_beat.lst[i].way !== e[128*i+64 +: 50])
            report_mismatch("list way", 256'(e[128*i+64 +: 50]),
                            256'(inspect_beat.lst[i].way));
          if (inspect_beat.lst[i].prev !== e[128*i+32 +: 32])
            report_mismatch("list prev", 256'(e[128*i+32 +: 32]),
                            256'(inspect_beat.lst[i].prev));
          if (inspect_beat.lst[i].next !== e[128*i +: 32])
            report_mismatch("list next", 256'(e[128*i +: 32]),
                            256'(inspect_beat.lst[i].next));
        end
      end
      default: begin
        if (inspect_beat !== e) report_mismatch("inspect_beat", e, inspect_beat);
      end
    endcase
    @(negedge clk);
    if (inspect_valid !== 1'b0) // single cycle pulse
      report_mismatch("inspect_valid", 256'(0), 256'(inspect_valid));
  endtask

  task automatic release_bresp();
    int n;
    @(negedge clk);
    // full fifo must hold off the next address
    if (awready !== (bid_q.size() < bresp_depth))
      report_mismatch("awready", 256'(bid_q.size() < bresp_depth), 256'(awready));
    @(posedge clk);
    #1;
    bready = 1'b1;
    n = 0;
    while (bid_q.size() != 0 && n < timeout) begin
      @(posedge clk);
      n++;
    end
    if (bid_q.size() != 0) report_timeout("pending write responses to drain");
  endtask

  // b handshake happens at the edge after a negedge that sees valid and ready
  always @(negedge clk) begin
    if (rst_n && b.valid && bready) begin
      b_seen++;
      if (bid_q.size() == 0) begin
        errors++;
        $display("write response with id %0h arrived with no write outstanding", b.id);
      end else begin
        if (b.id !== bid_q[0]) report_mismatch("bid", 256'(bid_q[0]), 256'(b.id));
        if (b.resp !== 2'b00) report_mismatch("bresp", 256'(0), 256'(b.resp));
        bid_q.delete(0);
      end
    end
  end

  initial begin
    int n;
    void'($urandom(32'h4705)); // seeds this thread
    errors       = 0;
    timeouts     = 0;
    writes       = 0;
    b_seen       = 0;
    aw           = '0;
    w            = '0;
    ar           = '0;
    bready       = 1'b1;
    rready       = 1'b0;
    inspect_req  = 1'b0;
    inspect_addr = '0;
    build_table();

    n = 0;
    while (rst_n !== 1'b1 && n < timeout) begin
      @(posedge clk);
      n++;
    end
    @(negedge clk);
    if (rst_n !== 1'b1) report_timeout("reset release");
    // idle state straight out of reset
    if (b.valid !== 1'b0) report_mismatch("bvalid", 256'(0), 256'(b.valid));
    if (r.valid !== 1'b0) report_mismatch("rvalid", 256'(0), 256'(r.valid));
    if (inspect_valid !== 1'b0) report_mismatch("inspect_valid", 256'(0), 256'(inspect_valid));
    if (awready !== 1'b1) report_mismatch("awready", 256'(1), 256'(awready));
    if (wready !== 1'b1) report_mismatch("wready", 256'(1), 256'(wready));
    if (arready !== 1'b1) report_mismatch("arready", 256'(1), 256'(arready));

    foreach (rows[j]) begin
      @(posedge clk);
      #1;
      case (rows[j].kind)
        op_write:    do_write(rows[j]);
        op_read:     do_read(rows[j]);
        op_inspect:  do_inspect(rows[j]);
        op_bhold:    bready = 1'b0;
        op_brelease: release_bresp();
        default:     ;
      endcase
      if (timeouts != 0) break; // a stuck handshake ends the row loop
    end

    n = 0;
    while (bid_q.size() != 0 && n < timeout) begin
      @(posedge clk);
      n++;
    end
    if (bid_q.size() != 0) report_timeout("final write responses");
    if (b_seen != writes) report_mismatch("write response count", 256'(writes), 256'(b_seen));

    $display("errors %0d, timeouts %0d, writes %0d, write responses %0d",
             errors, timeouts, writes, b_seen);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int half_period = 20, // ns
  parameter int rst_cycles  = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release lands just after an edge, same as the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== rtl/hacd_axi_mem_top.sv ====
`timescale 1ns/1ps

module hacd_axi_mem_top
  import hacd_axi_pkg::*;
  import hacd_table_pkg::*;
#(
  parameter int mem_lines   = 64,
  parameter int bresp_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_aw_t               aw,
  input  axi_w_t                w,
  input  axi_ar_t               ar,
  input  logic                  bready,
  input  logic                  rready,
  input  logic                  inspect_req,
  input  logic [axi_addr_w-1:0] inspect_addr,
  output logic                  awready,
  output logic                  wready,
  output logic                  arready,
  output axi_b_t                b,
  output axi_r_t                r,
  output logic                  inspect_valid,
  output table_region_e         inspect_region,
  output table_beat_u           inspect_beat
);

  localparam int lw = $clog2(mem_lines);

  // write path
  mem_wr_t             mem_wr;
  logic                fifo_full;
  logic                bid_push;
  logic [axi_id_w-1:0] bid;

  // port a, read controller
  logic                  rd_a_en;
  logic [lw-1:0]         rd_a_line;
  logic [beat_w-1:0]     rd_a_beat;
  logic [axi_data_w-1:0] rd_a_data;

  // port b, inspector
  logic                  rd_b_en;
  logic [lw-1:0]         rd_b_line;
  logic [beat_w-1:0]     rd_b_beat;
  logic [axi_data_w-1:0] rd_b_data;

  hacd_axi_wr_ctrl #(.mem_lines(mem_lines)) u_wr_ctrl (
    .clk, .rst_n, .aw, .w, .fifo_full, .awready, .wready,
    .wr(mem_wr), .bid_push, .bid
  );

  hacd_bresp_fifo #(.bresp_depth(bresp_depth)) u_bresp_fifo (
    .clk, .rst_n, .push(bid_push), .push_id(bid), .bready, .full(fifo_full), .b
  );

  hacd_axi_rd_ctrl #(.mem_lines(mem_lines)) u_rd_ctrl (
    .clk, .rst_n, .ar, .rready, .rd_data(rd_a_data), .arready,
    .rd_en(rd_a_en), .rd_line(rd_a_line), .rd_beat(rd_a_beat), .r
  );

  hacd_line_mem #(.mem_lines(mem_lines)) u_line_mem (
    .clk, .wr(mem_wr),
    .rd_a_en, .rd_a_line, .rd_a_beat,
    .rd_b_en, .rd_b_line, .rd_b_beat,
    .rd_a_data, .rd_b_data
  );

  hacd_table_inspect #(.mem_lines(mem_lines)) u_table_inspect (
    .clk, .rst_n, .inspect_req, .inspect_addr, .rd_data(rd_b_data),
    .rd_en(rd_b_en), .rd_line(rd_b_line), .rd_beat(rd_b_beat),
    .inspect_valid, .inspect_region, .inspect_beat
  );

endmodule

// ==== rtl/hacd_table_inspect.sv ====
`timescale 1ns/1ps

module hacd_table_inspect
  import hacd_axi_pkg::*;
  import hacd_table_pkg::*;
#(
  parameter int mem_lines = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         inspect_req,
  input  logic [axi_addr_w-1:0]        inspect_addr,
  input  logic [axi_data_w-1:0]        rd_data,
  output logic                         rd_en,
  output logic [$clog2(mem_lines)-1:0] rd_line,
  output logic [beat_w-1:0]            rd_beat,
  output logic                         inspect_valid,
  output table_region_e                inspect_region,
  output table_beat_u                  inspect_beat
);

  localparam int lw = $clog2(mem_lines);

  table_region_e req_region;    // classified at request
  logic          req_q;         // fetch in progress
  table_region_e req_region_q;
  logic          valid_q;
  table_region_e region_q;
  table_beat_u   beat_q;

  // address against the region bases
  always_comb begin
    if (inspect_addr >= hawk_att_start && inspect_addr < hawk_list_start) begin
      req_region = region_att;
    end else if (inspect_addr >= hawk_list_start && inspect_addr < hawk_ppa_start) begin
      req_region = region_list;
    end else begin
      req_region = region_none; // outside table space, raw beat only
    end
  end

  // memory lookup starts on the request cycle itself
  assign rd_en   = inspect_req;
  assign rd_line = inspect_addr[line_lsb +: lw];
  assign rd_beat = inspect_addr[beat_lsb +: beat_w];

  assign inspect_valid  = valid_q;
  assign inspect_region = region_q;
  assign inspect_beat   = beat_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q        <= 1'b0;
      req_region_q <= region_none;
      valid_q      <= 1'b0;
      region_q     <= region_none;
    end else begin
      req_q   <= inspect_req;
      valid_q <= req_q;             // single pulse, two cycles after req
      if (inspect_req) begin
        req_region_q <= req_region; // rides along with the fetch
      end
      if (req_q) begin
        region_q <= req_region_q;
      end
    end
  end

  // beat and region stay until the next result
  always_ff @(posedge clk) begin
    if (req_q) begin
      beat_q <= table_beat_u'(rd_data);
    end
  end

endmodule

// ==== rtl/hacd_axi_rd_ctrl.sv ====
`timescale 1ns/1ps

module hacd_axi_rd_ctrl
  import hacd_axi_pkg::*;
#(
  parameter int mem_lines = 64
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  axi_ar_t                      ar,
  input  logic                         rready,
  input  logic [axi_data_w-1:0]        rd_data,
  output logic                         arready,
  output logic                         rd_en,
  output logic [$clog2(mem_lines)-1:0] rd_line,
  output logic [beat_w-1:0]            rd_beat,
  output axi_r_t                       r
);

  localparam int lw    = $clog2(mem_lines);
  localparam int cnt_w = $clog2(max_beats + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_hold
  } rd_state_e;

  rd_state_e             state;
  logic                  fetch_wait;  // memory data lands next cycle
  logic [axi_id_w-1:0]   cap_id;
  logic [lw-1:0]         cap_line;
  logic [beat_w-1:0]     cur_beat;
  logic [cnt_w-1:0]      beats_left;
  logic                  r_valid_q;
  logic                  r_last_q;
  logic [axi_id_w-1:0]   r_id_q;
  logic [axi_data_w-1:0] r_data_q;
  logic                  load;

  assign arready = (state == st_idle); // one read in flight
  assign rd_en   = (state == st_fetch) && !fetch_wait;
  assign rd_line = cap_line;
  assign rd_beat = cur_beat;
  assign load    = (state == st_fetch) && fetch_wait;

  assign r = '{valid: r_valid_q, id: r_id_q, data: r_data_q,
               resp: axi_resp_okay, last: r_last_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      fetch_wait <= 1'b0;
      cur_beat   <= '0;
      beats_left <= '0;
      r_valid_q  <= 1'b0;
      r_last_q   <= 1'b0;
    end else begin
      fetch_wait <= rd_en;
      case (state)
        st_idle: begin
          if (ar.valid) begin
            state      <= st_fetch;
            cur_beat   <= '0;
            beats_left <= cnt_w'(ar.len) + cnt_w'(1);
          end
        end
        st_fetch: begin
          if (load) begin
            state     <= st_hold;
            r_valid_q <= 1'b1;
            r_last_q  <= (beats_left == cnt_w'(1));
          end
        end
        st_hold: begin
          if (rready) begin         // beat taken
            r_valid_q <= 1'b0;
            r_last_q  <= 1'b0;
            if (beats_left == cnt_w'(1)) begin
              state <= st_idle;
            end else begin
              state      <= st_fetch;  // next beat, two cycles out
              cur_beat   <= cur_beat + 1'b1;
              beats_left <= beats_left - cnt_w'(1);
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload regs, only move on capture or load
  always_ff @(posedge clk) begin
    if (arready && ar.valid) begin
      cap_id   <= ar.id;
      cap_line <= ar.addr[line_lsb +: lw];
    end
    if (load) begin
      r_id_q   <= cap_id;
      r_data_q <= rd_data;
    end
  end

  // no payload change under back-pressure
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    r.valid && !rready |=> $stable(r));

endmodule

// ==== rtl/hacd_bresp_fifo.sv ====
`timescale 1ns/1ps

module hacd_bresp_fifo
  import hacd_axi_pkg::*;
#(
  parameter int bresp_depth = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push,
  input  logic [axi_id_w-1:0] push_id,
  input  logic                bready,
  output logic                full,
  output axi_b_t              b
);

  localparam int pw = (bresp_depth > 1) ? $clog2(bresp_depth) : 1;

  logic [axi_id_w-1:0] id_buf [bresp_depth];
  logic [pw-1:0]       wr_ptr;
  logic [pw-1:0]       rd_ptr;
  logic [pw:0]         count;   // 0 .. bresp_depth
  logic                pop;

  // wrap also for depths that are not a power of two
  function automatic logic [pw-1:0] ptr_inc(input logic [pw-1:0] p);
    return (p == pw'(bresp_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full = (count == (pw+1)'(bresp_depth));
  assign pop  = b.valid && bready;

  // head of queue is the pending response
  assign b = '{valid: (count != '0), id: id_buf[rd_ptr], resp: axi_resp_okay};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      id_buf[wr_ptr] <= push_id;
    end
  end

  // write side holds awready low while full, so no push can land here
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |-> !push);

endmodule

// ==== rtl/hacd_axi_wr_ctrl.sv ====
`timescale 1ns/1ps

module hacd_axi_wr_ctrl
  import hacd_axi_pkg::*;
#(
  parameter int mem_lines = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  axi_aw_t             aw,
  input  axi_w_t              w,
  input  logic                fifo_full,
  output logic                awready,
  output logic                wready,
  output mem_wr_t             wr,
  output logic                bid_push,
  output logic [axi_id_w-1:0] bid
);

  localparam int lw    = $clog2(mem_lines);
  localparam int cnt_w = $clog2(max_beats + 1);

  typedef enum logic {
    st_idle,
    st_data
  } wr_state_e;

  wr_state_e           state;
  logic [axi_id_w-1:0] cap_id;
  logic [lw-1:0]       cap_line;
  logic [cnt_w-1:0]    beats_left;  // beats still to come
  logic [beat_w-1:0]   cur_beat;
  logic                wready_q;

  logic aw_fire;
  logic w_fire;
  logic w_final;

  // no new address while a response slot is missing
  assign awready = (state == st_idle) && !fifo_full;
  assign wready  = wready_q;

  assign aw_fire = aw.valid && awready;
  assign w_fire  = w.valid && wready_q && (state == st_data);
  assign w_final = (beats_left == cnt_w'(1));

  // beat goes straight into memory on its handshake edge
  assign wr = '{en: w_fire, line: mem_line_w'(cap_line), beat: cur_beat,
                data: w.data, be: w.strb};

  assign bid_push = w_fire && w_final; // id queued with the last beat
  assign bid      = cap_id;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      beats_left <= '0;
      cur_beat   <= '0;
      wready_q   <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (aw_fire) begin
            state      <= st_data;
            beats_left <= cnt_w'(aw.len) + cnt_w'(1);
            cur_beat   <= '0;
            wready_q   <= 1'b1;
          end
        end
        st_data: begin
          if (w_fire) begin
            beats_left <= beats_left - cnt_w'(1);
            cur_beat   <= cur_beat + 1'b1;
            if (w_final) begin
              state    <= st_idle;
              wready_q <= 1'b0; // back up at the next aw
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // id and line taken at the aw handshake
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      cap_id   <= aw.id;
      cap_line <= aw.addr[line_lsb +: lw];
    end
  end

  // a burst never crosses the 64 byte line
  a_len_max: assert property (@(posedge clk) disable iff (!rst_n)
    aw_fire |-> aw.len <= 8'(max_beats - 1));

  // master wlast agrees with the len captured at aw
  a_wlast_cnt: assert property (@(posedge clk) disable iff (!rst_n)
    w_fire |-> (w.last == w_final));

endmodule

// ==== rtl/hacd_line_mem.sv ====
`timescale 1ns/1ps

module hacd_line_mem
  import hacd_axi_pkg::*;
#(
  parameter int mem_lines = 64
) (
  input  logic                         clk,
  input  mem_wr_t                      wr,
  input  logic                         rd_a_en,
  input  logic [$clog2(mem_lines)-1:0] rd_a_line,
  input  logic [beat_w-1:0]            rd_a_beat,
  input  logic                         rd_b_en,
  input  logic [$clog2(mem_lines)-1:0] rd_b_line,
  input  logic [beat_w-1:0]            rd_b_beat,
  output logic [axi_data_w-1:0]        rd_a_data,
  output logic [axi_data_w-1:0]        rd_b_data
);

  localparam int lw    = $clog2(mem_lines);
  localparam int depth = mem_lines * max_beats; // beats stored

  logic [axi_data_w-1:0] mem [depth];

  logic [lw+beat_w-1:0] wr_idx;
  logic [lw+beat_w-1:0] rd_a_idx;
  logic [lw+beat_w-1:0] rd_b_idx;

  // beat index is {line, beat}
  assign wr_idx   = {wr.line[lw-1:0], wr.beat}; // upper line bits unused here
  assign rd_a_idx = {rd_a_line, rd_a_beat};
  assign rd_b_idx = {rd_b_line, rd_b_beat};

  // byte lane merge, lanes without enable keep old contents
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int i = 0; i < axi_strb_w; i++) begin
        if (wr.be[i]) begin
          mem[wr_idx][i*8 +: 8] <= wr.data[i*8 +: 8];
        end
      end
    end
  end

  // port a, read controller
  always_ff @(posedge clk) begin
    if (rd_a_en) begin
      rd_a_data <= mem[rd_a_idx]; // old data on a same-edge write
    end
  end

  // port b, table inspection
  always_ff @(posedge clk) begin
    if (rd_b_en) begin
      rd_b_data <= mem[rd_b_idx];
    end
  end

endmodule

// ==== rtl/hacd_table_pkg.sv ====
package hacd_table_pkg;

  // translation table entry, 4 per beat
  // bit layout msb first: zpd_cnt 63:57, way 56:2, sts 1:0
  typedef struct packed {
    logic [6:0]  zpd_cnt; // zero page count
    logic [54:0] way;
    logic [1:0]  sts;
  } att_entry_t;

  // free list entry, 2 per beat
  // rsvd 127:114, way 113:64, prev 63:32, next 31:0
  typedef struct packed {
    logic [13:0] rsvd;
    logic [49:0] way;
    logic [31:0] prev;    // list links are entry indices
    logic [31:0] next;
  } list_entry_t;

  localparam int att_per_beat  = 4;
  localparam int list_per_beat = 2;

  // one stored beat, read either as att entries or list entries
  // entry 0 sits in the low bits
  typedef union packed {
    att_entry_t  [att_per_beat-1:0]  att;
    list_entry_t [list_per_beat-1:0] lst;
  } table_beat_u;

  // which view of table_beat_u applies
  typedef enum logic [1:0] {
    region_none = 2'd0,
    region_att  = 2'd1,
    region_list = 2'd2
  } table_region_e;

  // region bases, byte addresses
  // att  [att_start, list_start)
  // list [list_start, ppa_start)
  localparam logic [63:0] hawk_att_start  = 64'h0000_0000_0000_0400;
  localparam logic [63:0] hawk_list_start = 64'h0000_0000_0000_0800;
  localparam logic [63:0] hawk_ppa_start  = 64'h0000_0000_0000_0c00; // pages beyond

endpackage

// ==== rtl/hacd_axi_pkg.sv ====
package hacd_axi_pkg;

  // bus widths as seen by the compression engine
  localparam int axi_data_w = 256;
  localparam int axi_strb_w = axi_data_w / 8; // 32 byte lanes
  localparam int axi_id_w   = 6;
  localparam int axi_addr_w = 64;

  // a 64 byte line is two 256 bit beats, so bursts are 1 or 2 beats
  localparam int max_beats = 2;
  localparam int beat_w    = $clog2(max_beats);

  // byte address layout of a line
  localparam int beat_lsb = $clog2(axi_strb_w); // addr[5] picks the beat
  localparam int line_lsb = beat_lsb + beat_w;  // line index starts at addr[6]

  // line field of the internal write port, wide enough for any mem_lines
  localparam int mem_line_w = 16;

  localparam logic [1:0] axi_resp_okay = 2'b00; // only response ever sent

  typedef struct packed {
    logic                  valid;
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;   // beats minus one
  } axi_aw_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [7:0]            len;
  } axi_ar_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic                valid;
    logic [axi_id_w-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic                  valid;
    logic [axi_id_w-1:0]   id;
    logic [axi_data_w-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  // write port into the line storage
  typedef struct packed {
    logic                  en;
    logic [mem_line_w-1:0] line;
    logic [beat_w-1:0]     beat;
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] be;    // one bit per byte
  } mem_wr_t;

endpackage
